// File: source/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int BLOCK_BYTES  = 8;
    localparam int OFFSET_BITS  = 3;
    localparam int CACHE_LINES  = 16;
    localparam int INDEX_BITS   = 4;
    localparam int TAG_BITS     = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    // zero tag means not granted
    localparam int MEM_TAG_BITS = 4;
    localparam int REQ_ID_BITS  = 4;

    typedef logic [8*BLOCK_BYTES-1:0] block_t;

    typedef enum logic {MEM_OP_LOAD, MEM_OP_STORE} mem_op_e;
    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;
    typedef enum logic [1:0] {CMD_NONE, CMD_LOAD, CMD_STORE} mem_cmd_e;
    typedef enum logic [1:0] {MSHR_INVALID, MSHR_PENDING, MSHR_WAIT_DATA} mshr_state_e;

    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        mem_size_e              size;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [31:0]            data;
        logic [REQ_ID_BITS-1:0] id;
    } cache_req_t;

    typedef struct packed {
        logic                   valid;
        logic [REQ_ID_BITS-1:0] id;
        logic [31:0]            data;
    } load_resp_t;

    typedef struct packed {
        mem_op_e                op;
        mem_size_e              size;
        logic [OFFSET_BITS-1:0] offset;
        logic [31:0]            data;
        logic [REQ_ID_BITS-1:0] id;
    } queued_req_t;

    typedef struct packed {
        mem_cmd_e              command;
        logic [ADDR_WIDTH-1:0] addr;
        block_t                data;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_TAG_BITS-1:0] tag;
        block_t                  data;
    } mem_resp_t;

    // line being filled, queued requests travel beside it
    typedef struct packed {
        logic                  valid;
        logic [INDEX_BITS-1:0] index;
        logic [TAG_BITS-1:0]   tag;
        block_t                block;
    } refill_t;

endpackage

// File: source/miss_queue.sv
`timescale 1ns/10ps

module miss_queue
    import dcache_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          push,
    input  queued_req_t                   push_data,
    output logic                          full,
    input  logic                          pop_all,
    output queued_req_t [queue_depth-1:0] entries,
    output logic [queue_depth-1:0]        entry_valid
);

    localparam int COUNT_BITS = $clog2(queue_depth + 1);

    logic [COUNT_BITS-1:0] count;

    assign full = count == COUNT_BITS'(queue_depth);

    // drained all at once, so slot 0 is always the oldest
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (pop_all) begin
            count <= '0;
        end else if (push && !full) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (push && !full) begin
            entries[count] <= push_data;
        end
    end

    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            entry_valid[i] = COUNT_BITS'(i) < count;
        end
    end

    // the MSHR side refuses requests for a full queue
    a_no_push_full: assert property (@(posedge clock) disable iff (reset)
        push |-> !full)
        else $error("push into full miss queue");

    a_no_push_pop: assert property (@(posedge clock) disable iff (reset)
        pop_all |-> !push)
        else $error("push during refill drain");

endmodule

// File: source/mshr_control.sv
`timescale 1ns/10ps

module mshr_control
    import dcache_pkg::*;
#(
    parameter int mshr_entries = 4,
    parameter int queue_depth  = 4
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  cache_req_t                                miss_req,
    input  logic                                      lookup_hit,
    output logic                                      req_accept,
    output logic [mshr_entries-1:0]                   push,
    output queued_req_t                               push_data,
    input  logic [mshr_entries-1:0]                   queue_full,
    output logic [mshr_entries-1:0]                   pop_all,
    input  queued_req_t [mshr_entries-1:0][queue_depth-1:0] queue_entries,
    input  logic [mshr_entries-1:0][queue_depth-1:0]  queue_valid,
    output mem_req_t                                  load_cmd,
    input  logic                                      writeback_busy,
    input  logic [MEM_TAG_BITS-1:0]                   mem_grant_tag,
    input  mem_resp_t                                 mem_resp,
    output refill_t                                   refill,
    output queued_req_t [queue_depth-1:0]             refill_queue,
    output logic [queue_depth-1:0]                    refill_queue_valid
);

    localparam int ENTRY_BITS = (mshr_entries > 1) ? $clog2(mshr_entries) : 1;

    mshr_state_e             state       [mshr_entries];
    logic [TAG_BITS-1:0]     entry_tag   [mshr_entries];
    logic [INDEX_BITS-1:0]   entry_index [mshr_entries];
    logic [MEM_TAG_BITS-1:0] trans_tag   [mshr_entries];

    logic [TAG_BITS-1:0]     req_tag;
    logic [INDEX_BITS-1:0]   req_index;
    logic [mshr_entries-1:0] block_match, refill_match;
    logic [ENTRY_BITS-1:0]   free_idx, match_idx, pend_idx, refill_idx, target_idx;
    logic                    free_found, pend_found, any_match, refill_active;
    logic                    can_take, take_miss, alloc, issue_grant;

    assign req_tag   = miss_req.addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign req_index = miss_req.addr[OFFSET_BITS +: INDEX_BITS];

    // descending scan so the lowest entry wins
    always_comb begin
        free_found = 1'b0;
        pend_found = 1'b0;
        free_idx   = '0;
        pend_idx   = '0;
        match_idx  = '0;
        refill_idx = '0;
        for (int i = mshr_entries - 1; i >= 0; i--) begin
            block_match[i]  = state[i] != MSHR_INVALID && entry_tag[i] == req_tag
                              && entry_index[i] == req_index;
            refill_match[i] = state[i] != MSHR_INVALID && mem_resp.tag != '0
                              && trans_tag[i] == mem_resp.tag;
            if (state[i] == MSHR_INVALID) begin
                free_found = 1'b1;
                free_idx   = ENTRY_BITS'(i);
            end
            if (state[i] == MSHR_PENDING) begin
                pend_found = 1'b1;
                pend_idx   = ENTRY_BITS'(i);
            end
            if (block_match[i]) begin
                match_idx = ENTRY_BITS'(i);
            end
            if (refill_match[i]) begin
                refill_idx = ENTRY_BITS'(i);
            end
        end
    end

    assign any_match     = |block_match;
    assign refill_active = |refill_match;
    assign can_take      = any_match ? !queue_full[match_idx] : free_found;
    // hits stall too while a line is being filled
    assign req_accept    = !reset && !refill_active && (lookup_hit || can_take);
    assign take_miss     = miss_req.valid && req_accept;
    assign alloc         = take_miss && !any_match;
    assign target_idx    = any_match ? match_idx : free_idx;

    always_comb begin
        push = '0;
        if (take_miss) begin
            push[target_idx] = 1'b1;
        end
    end

    assign push_data = '{op: miss_req.op, size: miss_req.size,
                         offset: miss_req.addr[OFFSET_BITS-1:0],
                         data: miss_req.data, id: miss_req.id};

    always_comb begin
        load_cmd = '{command: CMD_NONE, addr: '0, data: '0};
        if (pend_found && !writeback_busy) begin
            load_cmd.command = CMD_LOAD;
            load_cmd.addr    = {entry_tag[pend_idx], entry_index[pend_idx],
                                {OFFSET_BITS{1'b0}}};
        end
    end

    assign issue_grant = load_cmd.command == CMD_LOAD && mem_grant_tag != '0;

    assign pop_all            = refill_match;
    assign refill             = '{valid: refill_active, index: entry_index[refill_idx],
                                  tag: entry_tag[refill_idx], block: mem_resp.data};
    assign refill_queue       = queue_entries[refill_idx];
    assign refill_queue_valid = queue_valid[refill_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mshr_entries; i++) begin
                state[i] <= MSHR_INVALID;
            end
        end else begin
            if (alloc) begin
                state[free_idx] <= MSHR_PENDING;
            end
            if (issue_grant) begin
                state[pend_idx] <= MSHR_WAIT_DATA;
            end
            if (refill_active) begin
                state[refill_idx] <= MSHR_INVALID;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_tag[free_idx]   <= req_tag;
            entry_index[free_idx] <= req_index;
            trans_tag[free_idx]   <= '0;
        end
        if (issue_grant) begin
            trans_tag[pend_idx] <= mem_grant_tag;
        end
    end

    // a stale transaction tag must never wake an entry that has not issued
    for (genvar i = 0; i < mshr_entries; i++) begin : g_check
        a_pending_no_match: assert property (@(posedge clock) disable iff (reset)
            !(state[i] == MSHR_PENDING && refill_match[i]))
            else $error("pending entry %0d matched returned tag", i);
    end

endmodule

// File: source/cache_array.sv
`timescale 1ns/10ps

module cache_array
    import dcache_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  cache_req_t                    req,
    input  logic                          accept_miss,
    output logic                          lookup_hit,
    output load_resp_t                    hit_resp,
    output cache_req_t                    miss_req,
    input  refill_t                       refill,
    input  queued_req_t [queue_depth-1:0] refill_queue,
    input  logic [queue_depth-1:0]        refill_queue_valid,
    output load_resp_t [queue_depth-1:0]  miss_resp,
    input  mem_req_t                      load_cmd,
    output logic                          writeback_busy,
    output mem_req_t                      mem_req
);

    logic [CACHE_LINES-1:0] line_valid, line_dirty;
    logic [TAG_BITS-1:0]    line_tag  [CACHE_LINES];
    block_t                 line_data [CACHE_LINES];

    logic [INDEX_BITS-1:0]  req_index;
    logic [TAG_BITS-1:0]    req_tag;
    logic                   store_hit;
    block_t                 refill_block;
    logic                   refill_dirty;

    logic                   wb_valid;
    logic [ADDR_WIDTH-1:0]  wb_addr;
    block_t                 wb_data;

    function automatic block_t merge_store(block_t line, mem_size_e size,
                                           logic [OFFSET_BITS-1:0] offset,
                                           logic [31:0] data);
        block_t merged;
        merged = line;
        case (size)
            SIZE_BYTE: merged[{offset, 3'b000} +: 8]         = data[7:0];
            SIZE_HALF: merged[{offset[2:1], 4'b0000} +: 16]  = data[15:0];
            default:   merged[{offset[2], 5'b00000} +: 32]   = data;
        endcase
        return merged;
    endfunction

    assign req_index  = req.addr[OFFSET_BITS +: INDEX_BITS];
    assign req_tag    = req.addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign lookup_hit = line_valid[req_index] && line_tag[req_index] == req_tag;
    // accept is already low during a refill
    assign store_hit  = req.valid && req.op == MEM_OP_STORE && lookup_hit && accept_miss;

    always_comb begin
        hit_resp.valid = req.valid && req.op == MEM_OP_LOAD && lookup_hit && accept_miss;
        hit_resp.id    = req.id;
        hit_resp.data  = line_data[req_index][{req.addr[2], 5'b00000} +: 32];
        miss_req       = req;
        miss_req.valid = req.valid && !lookup_hit;
    end

    // queued requests in order, loads see only earlier stores
    always_comb begin
        refill_block = refill.block;
        refill_dirty = 1'b0;
        miss_resp    = '0;
        for (int i = 0; i < queue_depth; i++) begin
            if (refill.valid && refill_queue_valid[i]) begin
                if (refill_queue[i].op == MEM_OP_STORE) begin
                    refill_block = merge_store(refill_block, refill_queue[i].size,
                                               refill_queue[i].offset, refill_queue[i].data);
                    refill_dirty = 1'b1;
                end else begin
                    miss_resp[i].valid = 1'b1;
                    miss_resp[i].id    = refill_queue[i].id;
                    miss_resp[i].data  = refill_block[{refill_queue[i].offset[2], 5'b00000} +: 32];
                end
            end
        end
    end

    // write-back store wins over a load command
    always_comb begin
        mem_req = load_cmd;
        if (wb_valid) begin
            mem_req = '{command: CMD_STORE, addr: wb_addr, data: wb_data};
        end
    end

    assign writeback_busy = wb_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
            wb_valid   <= 1'b0;
        end else begin
            wb_valid <= refill.valid && line_valid[refill.index] && line_dirty[refill.index];
            if (refill.valid) begin
                line_valid[refill.index] <= 1'b1;
                line_dirty[refill.index] <= refill_dirty;
            end else if (store_hit) begin
                line_dirty[req_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (refill.valid) begin
            line_tag[refill.index]  <= refill.tag;
            line_data[refill.index] <= refill_block;
            wb_addr <= {line_tag[refill.index], refill.index, {OFFSET_BITS{1'b0}}};
            wb_data <= line_data[refill.index];
        end else if (store_hit) begin
            line_data[req_index] <= merge_store(line_data[req_index], req.size,
                                                req.addr[OFFSET_BITS-1:0], req.data);
        end
    end

    // refill stall must keep store hits off the line being filled
    a_refill_store_clash: assert property (@(posedge clock) disable iff (reset)
        refill.valid |-> !(store_hit && req_index == refill.index))
        else $error("refill and store hit on index %0d", refill.index);

endmodule

// File: source/dcache_top.sv
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int mshr_entries = 4,
    parameter int queue_depth  = 4
) (
    input  logic                              clock,
    input  logic                              reset,
    input  cache_req_t                        req,
    output logic                              req_accept,
    output load_resp_t                        hit_resp,
    output load_resp_t [queue_depth-1:0]      miss_resp,
    output mem_req_t                          mem_req,
    input  logic [MEM_TAG_BITS-1:0]           mem_grant_tag,
    input  mem_resp_t                         mem_resp
);

    logic                                      lookup_hit;
    cache_req_t                                miss_req;
    logic [mshr_entries-1:0]                   push;
    queued_req_t                               push_data;
    logic [mshr_entries-1:0]                   queue_full;
    logic [mshr_entries-1:0]                   pop_all;
    queued_req_t [mshr_entries-1:0][queue_depth-1:0] queue_entries;
    logic [mshr_entries-1:0][queue_depth-1:0]  queue_valid;
    mem_req_t                                  load_cmd;
    logic                                      writeback_busy;
    refill_t                                   refill;
    queued_req_t [queue_depth-1:0]             refill_queue;
    logic [queue_depth-1:0]                    refill_queue_valid;

    cache_array #(
        .queue_depth(queue_depth)
    ) u_cache_array (
        .clock              (clock),
        .reset              (reset),
        .req                (req),
        .accept_miss        (req_accept),
        .lookup_hit         (lookup_hit),
        .hit_resp           (hit_resp),
        .miss_req           (miss_req),
        .refill             (refill),
        .refill_queue       (refill_queue),
        .refill_queue_valid (refill_queue_valid),
        .miss_resp          (miss_resp),
        .load_cmd           (load_cmd),
        .writeback_busy     (writeback_busy),
        .mem_req            (mem_req)
    );

    mshr_control #(
        .mshr_entries(mshr_entries),
        .queue_depth (queue_depth)
    ) u_mshr_control (
        .clock              (clock),
        .reset              (reset),
        .miss_req           (miss_req),
        .lookup_hit         (lookup_hit),
        .req_accept         (req_accept),
        .push               (push),
        .push_data          (push_data),
        .queue_full         (queue_full),
        .pop_all            (pop_all),
        .queue_entries      (queue_entries),
        .queue_valid        (queue_valid),
        .load_cmd           (load_cmd),
        .writeback_busy     (writeback_busy),
        .mem_grant_tag      (mem_grant_tag),
        .mem_resp           (mem_resp),
        .refill             (refill),
        .refill_queue       (refill_queue),
        .refill_queue_valid (refill_queue_valid)
    );

    // one queue per entry
    for (genvar i = 0; i < mshr_entries; i++) begin : g_queue
        miss_queue #(
            .queue_depth(queue_depth)
        ) u_miss_queue (
            .clock       (clock),
            .reset       (reset),
            .push        (push[i]),
            .push_data   (push_data),
            .full        (queue_full[i]),
            .pop_all     (pop_all[i]),
            .entries     (queue_entries[i]),
            .entry_valid (queue_valid[i])
        );
    end

endmodule

// File: dv/mem_model.sv
`timescale 1ns/10ps

module mem_model
    import dcache_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    hold,
    input  mem_req_t                mem_req,
    output logic [MEM_TAG_BITS-1:0] mem_grant_tag,
    output mem_resp_t               mem_resp
);

    block_t                  store_mem [logic [ADDR_WIDTH-1:0]];
    logic [MEM_TAG_BITS-1:0] wait_tag  [$];
    logic [ADDR_WIDTH-1:0]   wait_addr [$];
    int                      wait_due  [$];
    logic [15:0]             lfsr;
    int                      cycle;
    logic                    grant_taken;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] pattern_word(logic [ADDR_WIDTH-1:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic block_t read_block(logic [ADDR_WIDTH-1:0] a);
        if (store_mem.exists(a)) begin
            return store_mem[a];
        end
        return {pattern_word(a + 4), pattern_word(a)};
    endfunction

    initial begin
        mem_grant_tag = 1;
        mem_resp      = '0;
        lfsr          = 16'd62;
        cycle         = 0;
        grant_taken   = 1'b0;
    end

    // commands are stable by the falling edge
    always @(negedge clock) begin
        int lat;
        if (reset) begin
            wait_tag.delete();
            wait_addr.delete();
            wait_due.delete();
        end else begin
            if (mem_req.command == CMD_LOAD) begin
                lat = 3;
                for (int b = 0; b < 3; b++) begin
                    lat += int'(lfsr[0]) << b;
                    lfsr = lfsr_next(lfsr);
                end
                wait_tag.push_back(mem_grant_tag);
                wait_addr.push_back(mem_req.addr);
                wait_due.push_back(cycle + lat);
                grant_taken = 1'b1;
            end
            if (mem_req.command == CMD_STORE) begin
                store_mem[mem_req.addr] = mem_req.data;
            end
        end
    end

    always @(posedge clock) begin
        bit sent;
        #1;
        cycle++;
        if (grant_taken) begin
            mem_grant_tag = (mem_grant_tag == 15) ? 1 : mem_grant_tag + 1;
            grant_taken   = 1'b0;
        end
        mem_resp = '0;
        sent     = 1'b0;
        // one return per cycle, first due entry wins
        for (int i = 0; i < wait_tag.size() && !hold && !sent; i++) begin
            if (wait_due[i] <= cycle) begin
                mem_resp = '{tag: wait_tag[i], data: read_block(wait_addr[i])};
                wait_tag.delete(i);
                wait_addr.delete(i);
                wait_due.delete(i);
                sent = 1'b1;
            end
        end
    end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb
    import dcache_pkg::*;
;

    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_TESTS   = 6;

    logic                         clock;
    logic                         reset;
    logic                         hold;
    cache_req_t                   req;
    logic                         req_accept;
    load_resp_t                   hit_resp;
    load_resp_t [QUEUE_DEPTH-1:0] miss_resp;
    mem_req_t                     mem_req;
    logic [MEM_TAG_BITS-1:0]      mem_grant_tag;
    mem_resp_t                    mem_resp;

    logic [31:0]      ref_words [1024];
    logic [31:0]      exp_data  [16];
    logic [15:0]      pending_load;
    logic [15:0]      tag_live;
    logic [8:0]       tag_block [16];
    logic [511:0]     block_live;
    logic [QUEUE_DEPTH-1:0] miss_valid;
    logic             expect_refuse;
    logic             refill_now;
    int               wb_count;

    dcache_top #(
        .mshr_entries(4),
        .queue_depth (QUEUE_DEPTH)
    ) u_dut (
        .clock         (clock),
        .reset         (reset),
        .req           (req),
        .req_accept    (req_accept),
        .hit_resp      (hit_resp),
        .miss_resp     (miss_resp),
        .mem_req       (mem_req),
        .mem_grant_tag (mem_grant_tag),
        .mem_resp      (mem_resp)
    );

    mem_model u_mem (
        .clock         (clock),
        .reset         (reset),
        .hold          (hold),
        .mem_req       (mem_req),
        .mem_grant_tag (mem_grant_tag),
        .mem_resp      (mem_resp)
    );

    function automatic logic [31:0] pattern_word(logic [ADDR_WIDTH-1:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic block_t ref_block(logic [ADDR_WIDTH-1:0] a);
        return {ref_words[{a[11:3], 1'b1}], ref_words[{a[11:3], 1'b0}]};
    endfunction

    task automatic fail_check(string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic apply_store(mem_size_e size, logic [ADDR_WIDTH-1:0] a, logic [31:0] d);
        case (size)
            SIZE_BYTE: ref_words[a[11:2]][{a[1:0], 3'b000} +: 8] = d[7:0];
            SIZE_HALF: ref_words[a[11:2]][{a[1], 4'b0000} +: 16] = d[15:0];
            default:   ref_words[a[11:2]] = d;
        endcase
    endtask

    // retries until accepted
    task automatic issue(mem_op_e op, mem_size_e size, logic [ADDR_WIDTH-1:0] a,
                         logic [31:0] d, logic [REQ_ID_BITS-1:0] id);
        bit done;
        done = 1'b0;
        while (!done) begin
            req = '{valid: 1'b1, op: op, size: size, addr: a, data: d, id: id};
            if (op == MEM_OP_LOAD) begin
                exp_data[id]     = ref_words[a[11:2]];
                pending_load[id] = 1'b1;
            end
            @(negedge clock);
            done = req_accept;
            @(posedge clock);
            #1;
        end
        req.valid = 1'b0;
        if (op == MEM_OP_STORE) begin
            apply_store(size, a, d);
        end
    endtask

    task automatic try_refused(logic [ADDR_WIDTH-1:0] a, logic [REQ_ID_BITS-1:0] id);
        req = '{valid: 1'b1, op: MEM_OP_LOAD, size: SIZE_WORD, addr: a, data: '0, id: id};
        expect_refuse = 1'b1;
        @(posedge clock);
        #1;
        expect_refuse = 1'b0;
        req.valid     = 1'b0;
    endtask

    task automatic wait_idle();
        while (pending_load != '0 || tag_live != '0) begin
            @(posedge clock);
        end
        repeat (3) @(posedge clock);
        #1;
    endtask

    assign refill_now = mem_resp.tag != '0 && tag_live[mem_resp.tag];

    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            miss_valid[i] = miss_resp[i].valid;
        end
    end

    // transaction tracking off the falling edge
    always @(negedge clock) begin
        if (reset) begin
            tag_live   = '0;
            block_live = '0;
            wb_count   = 0;
        end else begin
            if (refill_now) begin
                tag_live[mem_resp.tag]              = 1'b0;
                block_live[tag_block[mem_resp.tag]] = 1'b0;
            end
            if (mem_req.command == CMD_LOAD) begin
                tag_live[mem_grant_tag]          = 1'b1;
                tag_block[mem_grant_tag]         = mem_req.addr[11:3];
                block_live[mem_req.addr[11:3]]   = 1'b1;
            end
            if (mem_req.command == CMD_STORE) begin
                wb_count++;
            end
            if (hit_resp.valid) begin
                pending_load[hit_resp.id] = 1'b0;
            end
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (miss_resp[i].valid) begin
                    pending_load[miss_resp[i].id] = 1'b0;
                end
            end
        end
    end

    a_reset_quiet: assert property (@(negedge clock) reset |->
        !req_accept && mem_req.command == CMD_NONE && !hit_resp.valid && miss_valid == '0)
        else fail_check("outputs active during reset");

    a_hit_data: assert property (@(negedge clock) disable iff (reset)
        hit_resp.valid |-> pending_load[hit_resp.id] && hit_resp.data == exp_data[hit_resp.id])
        else fail_check("load hit data or id wrong");

    for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_miss_check
        a_miss_data: assert property (@(negedge clock) disable iff (reset)
            miss_resp[i].valid |-> pending_load[miss_resp[i].id]
                && miss_resp[i].data == exp_data[miss_resp[i].id])
            else fail_check("refill load answer wrong");
    end

    a_one_load: assert property (@(negedge clock) disable iff (reset)
        mem_req.command == CMD_LOAD |-> mem_req.addr[2:0] == 3'b000
            && mem_req.addr < 4096 && !block_live[mem_req.addr[11:3]])
        else fail_check("second load command for a block in flight");

    a_writeback: assert property (@(negedge clock) disable iff (reset)
        mem_req.command == CMD_STORE |-> $past(refill_now)
            && mem_req.addr[2:0] == 3'b000 && mem_req.addr < 4096
            && mem_req.data == ref_block(mem_req.addr))
        else fail_check("write-back timing, address or victim data wrong");

    a_refill_stall: assert property (@(negedge clock) disable iff (reset)
        refill_now |-> !req_accept)
        else fail_check("request accepted in refill cycle");

    a_refused: assert property (@(negedge clock) disable iff (reset)
        expect_refuse |-> !req_accept)
        else fail_check("request accepted without resources");

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #((NUM_TESTS * 200 + 3) * 10);
        $display("watchdog expired before the tests completed");
        $display("Something failed");
        $fatal(1);
    end

    initial begin
        reset         = 1'b1;
        hold          = 1'b0;
        req           = '0;
        expect_refuse = 1'b0;
        pending_load  = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_words[i] = pattern_word(i * 4);
        end
        for (int i = 0; i < 16; i++) begin
            exp_data[i]  = '0;
            tag_block[i] = '0;
        end
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        // primary load miss
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h100, '0, 1);
        wait_idle();

        // secondary misses on one block
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h20C, '0, 2);
        issue(MEM_OP_STORE, SIZE_WORD, 32'h20C, 32'hCAFE_0001, 0);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h20C, '0, 3);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h208, '0, 4);
        wait_idle();

        // store hits of each size, then load hits
        issue(MEM_OP_STORE, SIZE_BYTE, 32'h101, 32'h0000_00A7, 0);
        issue(MEM_OP_STORE, SIZE_HALF, 32'h102, 32'h0000_B00C, 0);
        issue(MEM_OP_STORE, SIZE_WORD, 32'h104, 32'h1234_5678, 0);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h100, '0, 5);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h104, '0, 6);
        wait_idle();

        // conflict on index 0 evicts the dirty line
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h180, '0, 7);
        wait_idle();

        // full queue, then all entries busy
        hold = 1'b1;
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h400, '0, 8);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h404, '0, 9);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h400, '0, 10);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h404, '0, 11);
        try_refused(32'h400, 15);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h410, '0, 12);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h420, '0, 13);
        issue(MEM_OP_LOAD, SIZE_WORD, 32'h430, '0, 14);
        try_refused(32'h440, 15);
        hold = 1'b0;
        wait_idle();

        if (pending_load != '0 || wb_count == 0) begin
            $display("loads left unanswered or no write-back seen");
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: vlog.f
source/dcache_pkg.sv
source/miss_queue.sv
source/mshr_control.sv
source/cache_array.sv
source/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/miss_queue.sv
  - source/mshr_control.sv
  - source/cache_array.sv
  - source/dcache_top.sv
  - target: test
    files:
      - dv/mem_model.sv
      - dv/dcache_tb.sv
